// File: Makefile
# Verilator build and run of the nora testbench

VERILATOR ?= verilator
TOP       ?= tb_nora
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, look for the pass message in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q -F '** PASS **' $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
logic/nora_bus_pkg.sv
logic/nora_regs_pkg.sv
logic/cpu_phaser.sv
logic/bus_controller.sv
logic/simple_via.sv
logic/sysregs.sv
logic/nora_top.sv
test/tb_nora.sv

// File: logic/bus_controller.sv
`timescale 1ns/1ns
// bus controller
// samples cpu cycles, decodes regions, drives memory strobes and slave bus
module bus_controller
(
    input  logic                    clk6x,
    input  logic                    arst_n_i,
    input  nora_bus_pkg::phase_t    phase_i,
    input  logic                    setup_cs_i,     // sample at end of PH2
    input  logic                    release_wr_i,   // end of PH4
    input  logic                    release_cs_i,   // end of PH5
    input  nora_bus_pkg::cpu_addr_t cpu_addr_i,
    input  nora_bus_pkg::byte_t     cpu_data_i,
    input  logic                    cpu_rwn_i,
    input  nora_bus_pkg::byte_t     mem_data_i,
    input  nora_bus_pkg::bank_t     bank_eff_i,     // masked bank from sysregs
    input  nora_bus_pkg::byte_t     via_datard_i,
    input  nora_bus_pkg::byte_t     scrb_datard_i,
    output nora_bus_pkg::byte_t     cpu_data_o,
    output nora_bus_pkg::mem_addr_t mem_addr_o,
    output nora_bus_pkg::byte_t     mem_data_o,
    output logic                    mem_rdn_o,
    output logic                    mem_wrn_o,
    output logic                    sram_csn_o,
    output logic                    vera_csn_o,
    output nora_bus_pkg::reg_ofs_t  slv_ofs_o,
    output nora_bus_pkg::byte_t     slv_datawr_o,
    output logic                    slv_wr_o,       // one clk6x, at end of PH4
    output logic                    via_req_o,
    output logic                    scrb_req_o
);

    nora_bus_pkg::region_t   region_n;
    nora_bus_pkg::region_t   region_q;
    nora_bus_pkg::mem_addr_t mem_addr_n;
    nora_bus_pkg::reg_ofs_t  ofs_q;         // slave register offset
    nora_bus_pkg::byte_t     data_q;        // cpu write data
    nora_bus_pkg::byte_t     rd_byte;
    logic                    rwn_q;
    logic                    mem_act;
    logic                    ph_strobe;

    // decode order: via, vera, scrb, bank window, rest is fixed sram
    always_comb
    begin
        if ((cpu_addr_i >> nora_bus_pkg::VIA_BITS)
            == (nora_bus_pkg::VIA_BASE >> nora_bus_pkg::VIA_BITS))
            region_n = nora_bus_pkg::RG_VIA;
        else if ((cpu_addr_i >> nora_bus_pkg::VERA_BITS)
            == (nora_bus_pkg::VERA_BASE >> nora_bus_pkg::VERA_BITS))
            region_n = nora_bus_pkg::RG_VERA;
        else if ((cpu_addr_i >> nora_bus_pkg::SCRB_BITS)
            == (nora_bus_pkg::SCRB_BASE >> nora_bus_pkg::SCRB_BITS))
            region_n = nora_bus_pkg::RG_SCRB;
        else if ((cpu_addr_i >> nora_bus_pkg::BANK_WIN_BITS)
            == (nora_bus_pkg::BANK_WIN_BASE >> nora_bus_pkg::BANK_WIN_BITS))
            region_n = nora_bus_pkg::RG_SRAM_BANK;
        else
            region_n = nora_bus_pkg::RG_SRAM_FIXED;
    end

    // bank above the window offset, else top 64k
    assign mem_addr_n = (region_n == nora_bus_pkg::RG_SRAM_BANK)
                        ? {bank_eff_i, cpu_addr_i[nora_bus_pkg::BANK_WIN_BITS-1:0]}
                        : {nora_bus_pkg::FIXED_BANK_TOP, cpu_addr_i};

    // cycle payload, held to end of cycle
    always_ff @(posedge clk6x)
    begin
        if (setup_cs_i)
        begin
            ofs_q      <= cpu_addr_i[nora_bus_pkg::OFS_W-1:0];
            data_q     <= cpu_data_i;
            mem_addr_o <= mem_addr_n;
        end
    end

    always_ff @(posedge clk6x or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            region_q   <= nora_bus_pkg::RG_SRAM_FIXED;
            rwn_q      <= 1'b1;
            sram_csn_o <= 1'b1;
            vera_csn_o <= 1'b1;
            via_req_o  <= 1'b0;
            scrb_req_o <= 1'b0;
            cpu_data_o <= nora_bus_pkg::IDLE_BYTE;
        end
        else
        begin
            if (setup_cs_i)
            begin
                region_q   <= region_n;
                rwn_q      <= cpu_rwn_i;
                sram_csn_o <= !((region_n == nora_bus_pkg::RG_SRAM_FIXED)
                               || (region_n == nora_bus_pkg::RG_SRAM_BANK));
                vera_csn_o <= (region_n != nora_bus_pkg::RG_VERA);
                via_req_o  <= (region_n == nora_bus_pkg::RG_VIA);
                scrb_req_o <= (region_n == nora_bus_pkg::RG_SCRB);
            end
            else if (release_cs_i)
            begin
                sram_csn_o <= 1'b1;     // cycle over
                vera_csn_o <= 1'b1;
                via_req_o  <= 1'b0;
                scrb_req_o <= 1'b0;
            end
            if (release_wr_i && rwn_q)
                cpu_data_o <= rd_byte;  // held until next read
        end
    end

    // read return source
    always_comb
    begin
        case (region_q)
            nora_bus_pkg::RG_SRAM_FIXED,
            nora_bus_pkg::RG_SRAM_BANK,
            nora_bus_pkg::RG_VERA:  rd_byte = mem_data_i;
            nora_bus_pkg::RG_VIA:   rd_byte = via_datard_i;
            nora_bus_pkg::RG_SCRB:  rd_byte = scrb_datard_i;
            default:                rd_byte = nora_bus_pkg::IDLE_BYTE;
        endcase
    end

    // rd/wr strobes only in PH3..PH4 of an external access
    assign mem_act   = !sram_csn_o || !vera_csn_o;
    assign ph_strobe = (phase_i == nora_bus_pkg::PH3) || (phase_i == nora_bus_pkg::PH4);
    assign mem_rdn_o = !(mem_act && rwn_q && ph_strobe);
    assign mem_wrn_o = !(mem_act && !rwn_q && ph_strobe);
    assign mem_data_o = data_q;

    // slave bus
    assign slv_ofs_o    = ofs_q;
    assign slv_datawr_o = data_q;
    assign slv_wr_o     = release_wr_i && !rwn_q && (via_req_o || scrb_req_o);

endmodule

// File: logic/cpu_phaser.sv
`timescale 1ns/1ns
// cpu phaser
// six-phase clk6x sequencer for cpu clock, bus strobes and run/stop
module cpu_phaser
(
    input  logic                 clk6x,
    input  logic                 arst_n_i,
    input  logic                 run_i,         // low parks cpu at cycle end
    output nora_bus_pkg::phase_t phase_o,
    output logic                 phi2_o,        // cpu phase clock
    output logic                 stopped_o,
    output logic                 setup_cs_o,    // high in PH2
    output logic                 release_wr_o,  // high in PH4
    output logic                 release_cs_o   // high in PH5
);

    nora_bus_pkg::phase_t phase_q;
    nora_bus_pkg::phase_t phase_n;
    logic                 stopped_n;

    always_comb
    begin
        stopped_n = stopped_o;
        case (phase_q)
            nora_bus_pkg::PH0:
            begin
                if (stopped_o && !run_i)
                    phase_n = nora_bus_pkg::PH0;    // stay parked
                else
                begin
                    phase_n   = nora_bus_pkg::PH1;
                    stopped_n = 1'b0;               // resume
                end
            end
            nora_bus_pkg::PH1: phase_n = nora_bus_pkg::PH2;
            nora_bus_pkg::PH2: phase_n = nora_bus_pkg::PH3;
            nora_bus_pkg::PH3: phase_n = nora_bus_pkg::PH4;
            nora_bus_pkg::PH4: phase_n = nora_bus_pkg::PH5;
            nora_bus_pkg::PH5:
            begin
                phase_n   = nora_bus_pkg::PH0;
                stopped_n = !run_i;                 // sampled at end of cycle
            end
            default: phase_n = nora_bus_pkg::PH0;
        endcase
    end

    // strobes decoded from next phase so they are glitch free
    always_ff @(posedge clk6x or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            phase_q      <= nora_bus_pkg::PH0;
            stopped_o    <= 1'b0;
            phi2_o       <= 1'b0;
            setup_cs_o   <= 1'b0;
            release_wr_o <= 1'b0;
            release_cs_o <= 1'b0;
        end
        else
        begin
            phase_q      <= phase_n;
            stopped_o    <= stopped_n;
            phi2_o       <= (phase_n == nora_bus_pkg::PH3) || (phase_n == nora_bus_pkg::PH4)
                            || (phase_n == nora_bus_pkg::PH5);
            setup_cs_o   <= (phase_n == nora_bus_pkg::PH2);
            release_wr_o <= (phase_n == nora_bus_pkg::PH4);
            release_cs_o <= (phase_n == nora_bus_pkg::PH5);
        end
    end

    assign phase_o = phase_q;

endmodule

// File: logic/nora_bus_pkg.sv
// nora bus package
// cpu and memory bus types, address map and cpu cycle enums
package nora_bus_pkg;

    localparam int CPU_AW = 16;             // 65c02 address width
    localparam int MEM_AW = 21;             // 2 MB memory space
    localparam int BANK_W = 8;              // up to 256 banks
    localparam int OFS_W  = 4;              // slave register offset

    typedef logic [CPU_AW-1:0] cpu_addr_t;
    typedef logic [7:0]        byte_t;
    typedef logic [MEM_AW-1:0] mem_addr_t;
    typedef logic [BANK_W-1:0] bank_t;
    typedef logic [OFS_W-1:0]  reg_ofs_t;

    // one cpu cycle = six clk6x phases
    typedef enum logic [2:0]
    {
        PH0, PH1, PH2,                      // phi2 low
        PH3, PH4, PH5                       // phi2 high
    } phase_t;

    // decoded target of a cpu cycle
    typedef enum logic [2:0]
    {
        RG_SRAM_FIXED,                      // top 64k of sram
        RG_SRAM_BANK,                       // banked 8k window
        RG_VIA,                             // internal gpio block
        RG_SCRB,                            // internal system regs
        RG_VERA                             // external video chip
    } region_t;

    // address map, base plus number of decoded low bits
    localparam cpu_addr_t VIA_BASE      = 16'h9F00;
    localparam int        VIA_BITS      = 4;        // 16 bytes
    localparam cpu_addr_t VERA_BASE     = 16'h9F20;
    localparam int        VERA_BITS     = 5;        // 32 bytes
    localparam cpu_addr_t SCRB_BASE     = 16'h9F50;
    localparam int        SCRB_BITS     = 4;        // 16 bytes
    localparam cpu_addr_t BANK_WIN_BASE = 16'hA000;
    localparam int        BANK_WIN_BITS = 13;       // 8 KB window

    // high mem bits for non-banked accesses
    localparam logic [MEM_AW-CPU_AW-1:0] FIXED_BANK_TOP = '1;

    localparam byte_t IDLE_BYTE = 8'hFF;    // undecoded reads

endpackage

// File: logic/nora_regs_pkg.sv
// nora register package
// register offsets and reset values of the internal slave blocks
package nora_regs_pkg;

    // gpio block offsets, 65c22 order
    typedef enum logic [3:0]
    {
        VIA_ORB  = 4'h0,                    // output reg b
        VIA_ORA  = 4'h1,                    // output reg a
        VIA_DDRB = 4'h2,                    // direction b, 1 = out
        VIA_DDRA = 4'h3                     // direction a
    } via_reg_t;

    // system control register offsets
    typedef enum logic [3:0]
    {
        SCRB_RAMBANK  = 4'h0,               // banked window select
        SCRB_BANKMASK = 4'h1                // and-mask on bank
    } scrb_reg_t;

    localparam nora_bus_pkg::bank_t RAMBANK_RST  = 8'h00;
    // only 128 banks after reset, clear of the fixed top area
    localparam nora_bus_pkg::bank_t BANKMASK_RST = 8'h7F;

endpackage

// File: logic/nora_top.sv
`timescale 1ns/1ns
// nora system controller top
// phaser, bus controller, gpio and system registers
module nora_top
(
    input  logic                      clk6x,          // 6x cpu clock
    input  logic                      arst_n_i,
    // cpu side
    input  nora_bus_pkg::cpu_addr_t   cpu_addr_i,
    input  nora_bus_pkg::byte_t       cpu_data_i,
    input  logic                      cpu_rwn_i,
    input  logic                      cpu_run_i,
    output logic                      cpu_phi2_o,
    output nora_bus_pkg::byte_t       cpu_data_o,
    output logic                      cpu_stopped_o,
    // memory side
    output nora_bus_pkg::mem_addr_t   mem_addr_o,
    output nora_bus_pkg::byte_t       mem_data_o,
    input  nora_bus_pkg::byte_t       mem_data_i,
    output logic                      mem_rdn_o,
    output logic                      mem_wrn_o,
    output logic                      sram_csn_o,
    output logic                      vera_csn_o,
    // gpio
    input  nora_bus_pkg::byte_t       gpio_a_i,
    input  nora_bus_pkg::byte_t       gpio_b_i,
    output nora_bus_pkg::byte_t       gpio_a_o,
    output nora_bus_pkg::byte_t       gpio_a_dir_o,
    output nora_bus_pkg::byte_t       gpio_b_o,
    output nora_bus_pkg::byte_t       gpio_b_dir_o
);

    nora_bus_pkg::phase_t   phase;
    logic                   setup_cs;       // cpu cycle strobes
    logic                   release_wr;
    logic                   release_cs;
    nora_bus_pkg::reg_ofs_t slv_ofs;        // internal slave bus
    nora_bus_pkg::byte_t    slv_datawr;
    logic                   slv_wr;
    logic                   via_req;
    logic                   scrb_req;
    nora_bus_pkg::byte_t    via_datard;
    nora_bus_pkg::byte_t    scrb_datard;
    nora_bus_pkg::bank_t    bank_eff;

    cpu_phaser i_phaser
    (
        .clk6x        (clk6x),
        .arst_n_i     (arst_n_i),
        .run_i        (cpu_run_i),
        .phase_o      (phase),
        .phi2_o       (cpu_phi2_o),
        .stopped_o    (cpu_stopped_o),
        .setup_cs_o   (setup_cs),
        .release_wr_o (release_wr),
        .release_cs_o (release_cs)
    );

    bus_controller i_busctrl
    (
        .clk6x         (clk6x),
        .arst_n_i      (arst_n_i),
        .phase_i       (phase),
        .setup_cs_i    (setup_cs),
        .release_wr_i  (release_wr),
        .release_cs_i  (release_cs),
        .cpu_addr_i    (cpu_addr_i),
        .cpu_data_i    (cpu_data_i),
        .cpu_rwn_i     (cpu_rwn_i),
        .mem_data_i    (mem_data_i),
        .bank_eff_i    (bank_eff),
        .via_datard_i  (via_datard),
        .scrb_datard_i (scrb_datard),
        .cpu_data_o    (cpu_data_o),
        .mem_addr_o    (mem_addr_o),
        .mem_data_o    (mem_data_o),
        .mem_rdn_o     (mem_rdn_o),
        .mem_wrn_o     (mem_wrn_o),
        .sram_csn_o    (sram_csn_o),
        .vera_csn_o    (vera_csn_o),
        .slv_ofs_o     (slv_ofs),
        .slv_datawr_o  (slv_datawr),
        .slv_wr_o      (slv_wr),
        .via_req_o     (via_req),
        .scrb_req_o    (scrb_req)
    );

    simple_via i_via
    (
        .clk6x        (clk6x),
        .arst_n_i     (arst_n_i),
        .req_i        (via_req),
        .wr_i         (slv_wr),
        .ofs_i        (slv_ofs),
        .datawr_i     (slv_datawr),
        .gpio_a_i     (gpio_a_i),
        .gpio_b_i     (gpio_b_i),
        .datard_o     (via_datard),
        .gpio_a_o     (gpio_a_o),
        .gpio_a_dir_o (gpio_a_dir_o),
        .gpio_b_o     (gpio_b_o),
        .gpio_b_dir_o (gpio_b_dir_o)
    );

    sysregs i_scrb
    (
        .clk6x      (clk6x),
        .arst_n_i   (arst_n_i),
        .req_i      (scrb_req),
        .wr_i       (slv_wr),
        .ofs_i      (slv_ofs),
        .datawr_i   (slv_datawr),
        .datard_o   (scrb_datard),
        .bank_eff_o (bank_eff)
    );

endmodule

// File: logic/simple_via.sv
`timescale 1ns/1ns
// simple via
// 65c22-style gpio block, two 8-bit ports with output and direction regs
module simple_via
(
    input  logic                   clk6x,
    input  logic                   arst_n_i,
    input  logic                   req_i,
    input  logic                   wr_i,          // write strobe, end of cycle
    input  nora_bus_pkg::reg_ofs_t ofs_i,
    input  nora_bus_pkg::byte_t    datawr_i,
    input  nora_bus_pkg::byte_t    gpio_a_i,      // pin levels
    input  nora_bus_pkg::byte_t    gpio_b_i,
    output nora_bus_pkg::byte_t    datard_o,
    output nora_bus_pkg::byte_t    gpio_a_o,
    output nora_bus_pkg::byte_t    gpio_a_dir_o,  // 1 = output
    output nora_bus_pkg::byte_t    gpio_b_o,
    output nora_bus_pkg::byte_t    gpio_b_dir_o
);

    nora_bus_pkg::byte_t ora_q;
    nora_bus_pkg::byte_t orb_q;
    nora_bus_pkg::byte_t ddra_q;
    nora_bus_pkg::byte_t ddrb_q;

    // output reg where driven, pin where input
    function automatic nora_bus_pkg::byte_t pin_mix(input nora_bus_pkg::byte_t out_reg,
                                                   input nora_bus_pkg::byte_t ddr,
                                                   input nora_bus_pkg::byte_t pin);
        return (out_reg & ddr) | (pin & ~ddr);
    endfunction

    always_ff @(posedge clk6x or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            ora_q  <= '0;
            orb_q  <= '0;
            ddra_q <= '0;           // all inputs after reset
            ddrb_q <= '0;
        end
        else if (req_i && wr_i)
        begin
            case (nora_regs_pkg::via_reg_t'(ofs_i))
                nora_regs_pkg::VIA_ORB:  orb_q  <= datawr_i;
                nora_regs_pkg::VIA_ORA:  ora_q  <= datawr_i;
                nora_regs_pkg::VIA_DDRB: ddrb_q <= datawr_i;
                nora_regs_pkg::VIA_DDRA: ddra_q <= datawr_i;
                default: ;          // unmapped offsets ignored
            endcase
        end
    end

    always_comb
    begin
        case (nora_regs_pkg::via_reg_t'(ofs_i))
            nora_regs_pkg::VIA_ORB:  datard_o = pin_mix(orb_q, ddrb_q, gpio_b_i);
            nora_regs_pkg::VIA_ORA:  datard_o = pin_mix(ora_q, ddra_q, gpio_a_i);
            nora_regs_pkg::VIA_DDRB: datard_o = ddrb_q;
            nora_regs_pkg::VIA_DDRA: datard_o = ddra_q;
            default:                 datard_o = nora_bus_pkg::IDLE_BYTE;
        endcase
    end

    assign gpio_a_o     = ora_q;
    assign gpio_a_dir_o = ddra_q;
    assign gpio_b_o     = orb_q;
    assign gpio_b_dir_o = ddrb_q;

endmodule

// File: logic/sysregs.sv
`timescale 1ns/1ns
// system control registers
// ram bank select and bank mask for the 8k window
module sysregs
(
    input  logic                   clk6x,
    input  logic                   arst_n_i,
    input  logic                   req_i,
    input  logic                   wr_i,
    input  nora_bus_pkg::reg_ofs_t ofs_i,
    input  nora_bus_pkg::byte_t    datawr_i,
    output nora_bus_pkg::byte_t    datard_o,
    output nora_bus_pkg::bank_t    bank_eff_o     // bank after mask
);

    nora_bus_pkg::bank_t rambank_q;
    nora_bus_pkg::bank_t bankmask_q;

    always_ff @(posedge clk6x or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            rambank_q  <= nora_regs_pkg::RAMBANK_RST;
            bankmask_q <= nora_regs_pkg::BANKMASK_RST;
        end
        else if (req_i && wr_i)
        begin
            case (nora_regs_pkg::scrb_reg_t'(ofs_i))
                nora_regs_pkg::SCRB_RAMBANK:  rambank_q  <= datawr_i;
                nora_regs_pkg::SCRB_BANKMASK: bankmask_q <= datawr_i;
                default: ;
            endcase
        end
    end

    // raw readback, mask applied only on the bank path
    always_comb
    begin
        case (nora_regs_pkg::scrb_reg_t'(ofs_i))
            nora_regs_pkg::SCRB_RAMBANK:  datard_o = rambank_q;
            nora_regs_pkg::SCRB_BANKMASK: datard_o = bankmask_q;
            default:                      datard_o = nora_bus_pkg::IDLE_BYTE;
        endcase
    end

    assign bank_eff_o = rambank_q & bankmask_q;

endmodule

// File: test/nora_tests.txt
# op addr wdata mem_byte gpio_a_i gpio_b_i | cpu_data mem_addr sel gpio_a gpio_a_dir gpio_b gpio_b_dir hold
# op R read, W write, S read then stop; sel 0 none, 1 sram, 2 vera; hex except hold (clocks)
R 9F51 00 00 00 00 7F 000000 0 00 00 00 00 0
R 9F50 00 00 00 00 00 000000 0 00 00 00 00 0
W 9F50 85 00 00 00 00 000000 0 00 00 00 00 0
R 9F50 00 00 00 00 85 000000 0 00 00 00 00 0
W B123 3C 00 00 00 00 00B123 1 00 00 00 00 0
R B123 00 A5 00 00 A5 00B123 1 00 00 00 00 0
W 9F51 FF 00 00 00 00 000000 0 00 00 00 00 0
R 9F51 00 00 00 00 FF 000000 0 00 00 00 00 0
W B123 5A 00 00 00 00 10B123 1 00 00 00 00 0
R A000 00 96 00 00 96 10A000 1 00 00 00 00 0
R BFFF 00 11 00 00 11 10BFFF 1 00 00 00 00 0
W 0200 77 00 00 00 00 1F0200 1 00 00 00 00 0
R FFFC 00 34 00 00 34 1FFFFC 1 00 00 00 00 0
R 0200 00 C3 00 00 C3 1F0200 1 00 00 00 00 0
R 9F25 00 E7 00 00 E7 1F9F25 2 00 00 00 00 0
W 9F25 42 00 00 00 00 1F9F25 2 00 00 00 00 0
W 9F03 F0 00 00 00 00 000000 0 00 F0 00 00 0
W 9F01 A5 00 00 00 00 000000 0 A5 F0 00 00 0
R 9F01 00 00 3C 00 AC 000000 0 A5 F0 00 00 0
W 9F02 0F 00 00 00 00 000000 0 A5 F0 00 0F 0
W 9F00 5A 00 00 00 00 000000 0 A5 F0 5A 0F 0
R 9F00 00 00 00 C3 CA 000000 0 A5 F0 5A 0F 0
R 9F03 00 00 00 00 F0 000000 0 A5 F0 5A 0F 0
R 9F02 00 00 00 00 0F 000000 0 A5 F0 5A 0F 0
R 9F07 00 00 00 00 FF 000000 0 A5 F0 5A 0F 0
R 9F5A 00 00 00 00 FF 000000 0 A5 F0 5A 0F 0
S 0300 00 21 00 00 21 1F0300 1 A5 F0 5A 0F 8
W 0301 99 00 00 00 00 1F0301 1 A5 F0 5A 0F 0
R 0301 00 99 00 00 99 1F0301 1 A5 F0 5A 0F 0
R 9F50 00 00 00 00 85 000000 0 A5 F0 5A 0F 0

// File: test/tb_nora.sv
`timescale 1ns/1ns
// nora top testbench
// plays the cpu and the memory, runs bus operations from the tests file
module tb_nora;

    logic                    clk6x = 1'b0;
    logic                    arst_n_i;
    nora_bus_pkg::cpu_addr_t cpu_addr;
    nora_bus_pkg::byte_t     cpu_wdata;         // cpu -> dut
    logic                    cpu_rwn;
    logic                    cpu_run;
    logic                    cpu_phi2;
    nora_bus_pkg::byte_t     cpu_rdata;         // dut -> cpu
    logic                    cpu_stopped;
    nora_bus_pkg::mem_addr_t mem_addr;
    nora_bus_pkg::byte_t     mem_wdata;
    nora_bus_pkg::byte_t     mem_rdata;         // driven by memory model
    logic                    mem_rdn;
    logic                    mem_wrn;
    logic                    sram_csn;
    logic                    vera_csn;
    nora_bus_pkg::byte_t     gpio_a_in;
    nora_bus_pkg::byte_t     gpio_b_in;
    nora_bus_pkg::byte_t     gpio_a_out;
    nora_bus_pkg::byte_t     gpio_a_dir;
    nora_bus_pkg::byte_t     gpio_b_out;
    nora_bus_pkg::byte_t     gpio_b_dir;

    // one entry per line of the tests file
    logic [7:0]              t_op[$];           // R, W or S
    nora_bus_pkg::cpu_addr_t t_addr[$];
    nora_bus_pkg::byte_t     t_wdata[$];
    nora_bus_pkg::byte_t     t_mbyte[$];        // byte the memory presents
    nora_bus_pkg::byte_t     t_gpa_i[$];
    nora_bus_pkg::byte_t     t_gpb_i[$];
    nora_bus_pkg::byte_t     t_rd[$];
    nora_bus_pkg::mem_addr_t t_maddr[$];
    logic [1:0]              t_sel[$];          // 0 none, 1 sram, 2 vera
    nora_bus_pkg::byte_t     t_ga[$];
    nora_bus_pkg::byte_t     t_gad[$];
    nora_bus_pkg::byte_t     t_gb[$];
    nora_bus_pkg::byte_t     t_gbd[$];
    int                      t_hold[$];         // stop length in clocks

    // memory model state
    nora_bus_pkg::byte_t     cur_mbyte;
    logic                    mem_seen;
    logic                    rd_seen;
    logic                    wr_seen;
    nora_bus_pkg::mem_addr_t lat_addr;
    nora_bus_pkg::byte_t     lat_data;
    logic                    lat_sram;
    logic                    lat_vera;

    int n_tests     = 0;
    int cur_line    = 0;
    int val_errs    = 0;
    int other_errs  = 0;
    int cycle_cnt   = 0;
    int cycle_limit = 0;                        // 0 until the file is read

    nora_top i_dut
    (
        .clk6x         (clk6x),
        .arst_n_i      (arst_n_i),
        .cpu_addr_i    (cpu_addr),
        .cpu_data_i    (cpu_wdata),
        .cpu_rwn_i     (cpu_rwn),
        .cpu_run_i     (cpu_run),
        .cpu_phi2_o    (cpu_phi2),
        .cpu_data_o    (cpu_rdata),
        .cpu_stopped_o (cpu_stopped),
        .mem_addr_o    (mem_addr),
        .mem_data_o    (mem_wdata),
        .mem_data_i    (mem_rdata),
        .mem_rdn_o     (mem_rdn),
        .mem_wrn_o     (mem_wrn),
        .sram_csn_o    (sram_csn),
        .vera_csn_o    (vera_csn),
        .gpio_a_i      (gpio_a_in),
        .gpio_b_i      (gpio_b_in),
        .gpio_a_o      (gpio_a_out),
        .gpio_a_dir_o  (gpio_a_dir),
        .gpio_b_o      (gpio_b_out),
        .gpio_b_dir_o  (gpio_b_dir)
    );

    always #5 clk6x = ~clk6x;                   // 10 ns clk6x

    // memory model, looks at strobes away from the rising edge
    always @(negedge clk6x)
    begin
        if (!mem_rdn || !mem_wrn)
        begin
            mem_seen = 1'b1;
            rd_seen  = rd_seen | !mem_rdn;
            wr_seen  = wr_seen | !mem_wrn;
            lat_addr = mem_addr;
            lat_data = mem_wdata;
            lat_sram = sram_csn;
            lat_vera = vera_csn;
        end
        if (!mem_rdn)
            mem_rdata = cur_mbyte;              // read data for PH4
    end

    // run limit
    always @(posedge clk6x)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit)
        begin
            $display("timeout: run still busy after %0d clk6x cycles", cycle_cnt);
            $display("%0d value errors, %0d other errors", val_errs, other_errs);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_byte(input string name, input nora_bus_pkg::byte_t exp,
                              input nora_bus_pkg::byte_t act);
        if (act !== exp)
        begin
            $display("error %s expected %h got %h (line %0d)", name, exp, act, cur_line);
            val_errs = val_errs + 1;
        end
    endtask

    task automatic check_addr(input string name, input nora_bus_pkg::mem_addr_t exp,
                              input nora_bus_pkg::mem_addr_t act);
        if (act !== exp)
        begin
            $display("error %s expected %h got %h (line %0d)", name, exp, act, cur_line);
            val_errs = val_errs + 1;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("error %s expected %h got %h (line %0d)", name, exp, act, cur_line);
            val_errs = val_errs + 1;
        end
    endtask

    task automatic report(input string what);
        $display("line %0d: %s", cur_line, what);
        other_errs = other_errs + 1;
    endtask

    task automatic read_tests();
        int                      fd;
        int                      cnt;
        string                   line_s;
        logic [7:0]              f_op;
        nora_bus_pkg::cpu_addr_t f_addr;
        nora_bus_pkg::byte_t     f_wd;
        nora_bus_pkg::byte_t     f_mb;
        nora_bus_pkg::byte_t     f_ga_i;
        nora_bus_pkg::byte_t     f_gb_i;
        nora_bus_pkg::byte_t     f_rd;
        nora_bus_pkg::mem_addr_t f_ma;
        logic [1:0]              f_sel;
        nora_bus_pkg::byte_t     f_ga;
        nora_bus_pkg::byte_t     f_gad;
        nora_bus_pkg::byte_t     f_gb;
        nora_bus_pkg::byte_t     f_gbd;
        int                      f_hold;
        fd = $fopen("test/nora_tests.txt", "r");
        if (fd == 0)
            report("cannot open test/nora_tests.txt");
        else
        begin
            while (!$feof(fd))
            begin
                cnt = $fgets(line_s, fd);
                if (cnt > 0 && line_s.len() > 1 && line_s.getc(0) != "#")
                begin
                    cnt = $sscanf(line_s, "%c %h %h %h %h %h %h %h %h %h %h %h %h %d",
                                  f_op, f_addr, f_wd, f_mb, f_ga_i, f_gb_i, f_rd, f_ma,
                                  f_sel, f_ga, f_gad, f_gb, f_gbd, f_hold);
                    if (cnt != 14)
                        report("malformed line in the tests file");
                    else
                    begin
                        t_op.push_back(f_op);
                        t_addr.push_back(f_addr);
                        t_wdata.push_back(f_wd);
                        t_mbyte.push_back(f_mb);
                        t_gpa_i.push_back(f_ga_i);
                        t_gpb_i.push_back(f_gb_i);
                        t_rd.push_back(f_rd);
                        t_maddr.push_back(f_ma);
                        t_sel.push_back(f_sel);
                        t_ga.push_back(f_ga);
                        t_gad.push_back(f_gad);
                        t_gb.push_back(f_gb);
                        t_gbd.push_back(f_gbd);
                        t_hold.push_back(f_hold);
                    end
                end
            end
            $fclose(fd);
        end
        n_tests = t_op.size();
        if (n_tests == 0)
            report("no tests read");
    endtask

    // sampled in PH0, one clk6x after phi2 fell
    task automatic check_result(input int i);
        if (t_op[i] != "W")
            check_byte("cpu_data_o", t_rd[i], cpu_rdata);
        if (t_sel[i] == 2'd0)
        begin
            if (mem_seen)
                report("memory strobe during an internal register access");
        end
        else if (!mem_seen)
            report("no memory strobe during an external access");
        else
        begin
            check_addr("mem_addr_o", t_maddr[i], lat_addr);
            check_bit("sram_csn_o", t_sel[i] != 2'd1, lat_sram);
            check_bit("vera_csn_o", t_sel[i] != 2'd2, lat_vera);
            if (t_op[i] == "W")
                check_byte("mem_data_o", t_wdata[i], lat_data);
            if (rd_seen != (t_op[i] != "W") || wr_seen != (t_op[i] == "W"))
                report("wrong memory strobe for the access direction");
        end
        check_byte("gpio_a_o", t_ga[i], gpio_a_out);
        check_byte("gpio_a_dir_o", t_gad[i], gpio_a_dir);
        check_byte("gpio_b_o", t_gb[i], gpio_b_out);
        check_byte("gpio_b_dir_o", t_gbd[i], gpio_b_dir);
    endtask

    // cpu parked in PH0, then released
    task automatic check_stop(input int i);
        int k;
        check_bit("cpu_stopped_o", 1'b1, cpu_stopped);
        mem_seen = 1'b0;
        rd_seen  = 1'b0;
        for (k = 0; k < t_hold[i]; k++)
        begin
            @(negedge clk6x);
            check_bit("cpu_phi2_o", 1'b0, cpu_phi2);
            check_bit("cpu_stopped_o", 1'b1, cpu_stopped);
        end
        if (mem_seen)
            report("memory strobe while the cpu is stopped");
        cpu_run = 1'b1;
        @(negedge clk6x);
        check_bit("cpu_stopped_o", 1'b0, cpu_stopped);
        @(negedge cpu_phi2);                    // resumed cycle repeats the read
        @(negedge clk6x);
        if (!rd_seen)
            report("no read strobe in the resumed cycle");
        else
            check_addr("mem_addr_o", t_maddr[i], lat_addr);
    endtask

    task automatic run_line(input int i);
        cur_line  = i + 1;
        mem_seen  = 1'b0;
        rd_seen   = 1'b0;
        wr_seen   = 1'b0;
        cpu_addr  = t_addr[i];
        cpu_wdata = t_wdata[i];
        cpu_rwn   = (t_op[i] != "W");
        cpu_run   = (t_op[i] != "S");           // low at PH5 end parks the cpu
        cur_mbyte = t_mbyte[i];
        gpio_a_in = t_gpa_i[i];
        gpio_b_in = t_gpb_i[i];
        @(negedge cpu_phi2);
        @(negedge clk6x);
        check_result(i);
        if (t_op[i] == "S")
            check_stop(i);
    endtask

    initial
    begin
        arst_n_i  = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_rwn   = 1'b1;
        cpu_run   = 1'b1;
        mem_rdata = '0;
        cur_mbyte = '0;
        gpio_a_in = '0;
        gpio_b_in = '0;
        mem_seen  = 1'b0;
        rd_seen   = 1'b0;
        wr_seen   = 1'b0;
        read_tests();
        cycle_limit = n_tests * 6 * 4 + 24;     // margin for reset and first cycle
        repeat (2) @(negedge clk6x);
        arst_n_i = 1'b1;
        @(negedge cpu_phi2);                    // align to PH0
        @(negedge clk6x);
        for (int i = 0; i < n_tests; i++)
            run_line(i);
        $display("%0d lines, %0d value errors, %0d other errors",
                 n_tests, val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule
